// ==== cmdProc.f ====
+incdir+rtl
rtl/cmdProcPkg.sv
rtl/frameTimer.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/sysCtrl.sv
rtl/cmdProcessor.sv
test/cmdProcessorTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f cmdProc.f --top-module cmdProcessorTb --Mdir obj_dir -o simv

out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"

// ==== test/cmdProc_golden.txt ====
# kind (S frame, T frame then timeout gap), input count, input bytes in hex,
# reply count, reply bytes in hex (ALU results low byte first)
S 2 BB 05 1 00
S 3 AA 05 3C 1 3C
S 2 BB 05 1 3C
S 4 CC 9C 35 00 2 D1 00
S 4 CC 10 20 01 2 F0 FF
S 4 CC 9C 35 02 2 4C 20
S 4 CC 9C 35 03 2 14 00
S 4 CC 9C 35 04 2 BD 00
S 4 CC 9C 35 05 2 A9 00
S 4 CC 9C 35 06 2 80 13
S 4 CC 9C 35 07 2 04 00
S 2 DD 02 2 4C 20
S 3 AA 00 07 1 07
S 3 AA 01 09 1 09
S 2 DD 02 2 3F 00
S 1 55 0
S 4 CC 03 04 09 0
S 2 DD 0C 0
S 2 DD 00 2 07 00
T 2 AA 03 0
S 2 BB 03 1 00
T 3 CC 11 22 0
S 2 DD 00 2 33 00

// ==== test/cmdProcessorTb.sv ====
`timescale 1ns/1ps
`include "cmdProc_macros.svh"

module cmdProcessorTb;

   localparam int MaxBytes  = 8;
   localparam int WaitLimit = 200;

   logic       CLK;
   logic       RST;
   logic [7:0] rxData;
   logic       rxValid;
   logic       rxReady;
   logic [7:0] txData;
   logic       txValid;
   logic       txReady;

   integer     seed = 32'hddfc5363;
   int         errors;
   int         nIn;
   int         nOut;
   logic [7:0] inBytes [MaxBytes];
   logic [7:0] expBytes [MaxBytes];

   cmdProcessor u_cmdProcessor (
      .CLK(CLK), .RST(RST), .rxData(rxData), .rxValid(rxValid), .rxReady(rxReady),
      .txData(txData), .txValid(txValid), .txReady(txReady)
   );

   initial
   begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // Inputs change 1 ns after the rising edge
   task automatic idleCycles(input int n);
      repeat (n)
      begin
         @(posedge CLK);
         #1;
      end
   endtask

   task automatic readRecord(input int fd, output bit ok, output logic [7:0] kind);
      string line;
      int    code;
      int    k;
      ok = 1'b0;
      kind = 8'h00;
      code = $fscanf(fd, " %c", kind);
      // Skip comment lines
      while (code == 1 && kind == "#")
      begin
         code = $fgets(line, fd);
         code = $fscanf(fd, " %c", kind);
      end
      if (code == 1)
      begin
         code = $fscanf(fd, "%d", nIn);
         for (k = 0; k < nIn; k++)
            code = $fscanf(fd, "%h", inBytes[k]);
         code = $fscanf(fd, "%d", nOut);
         for (k = 0; k < nOut; k++)
            code = $fscanf(fd, "%h", expBytes[k]);
         ok = 1'b1;
      end
   endtask

   task automatic sendBytes();
      int k;
      int waited;
      for (k = 0; k < nIn; k++)
      begin
         idleCycles($random(seed) & 3);
         rxData  = inBytes[k];
         rxValid = 1'b1;
         waited  = 0;
         while (!rxReady && waited < WaitLimit)
         begin
            idleCycles(1);
            waited++;
         end
         if (!rxReady)
         begin
            $display("Timeout at %0t: input byte %0d never accepted", $time, k);
            errors++;
         end
         else
            idleCycles(1);
         rxValid = 1'b0;
      end
   endtask

   task automatic collectReply();
      int j;
      int waited;
      for (j = 0; j < nOut; j++)
      begin
         txReady = ($random(seed) & 1) != 0;
         waited  = 0;
         while (!(txValid && txReady) && waited < WaitLimit)
         begin
            idleCycles(1);
            txReady = ($random(seed) & 1) != 0;
            waited++;
         end
         if (!(txValid && txReady))
         begin
            $display("Timeout at %0t: reply byte %0d never arrived", $time, j);
            errors++;
            break;
         end
         assert (txData == expBytes[j])
         else
         begin
            $display("Mismatch at %0t: txData = %h, expected %h", $time, txData, expBytes[j]);
            errors++;
         end
         // Input stays blocked until the reply is taken
         assert (!rxReady)
         else
         begin
            $display("Mismatch at %0t: rxReady = %b, expected 0", $time, rxReady);
            errors++;
         end
         idleCycles(1);
      end
      txReady = 1'b0;
      // No extra byte may follow
      for (j = 0; j < 20; j++)
      begin
         idleCycles(1);
         assert (!txValid)
         else
         begin
            $display("Unexpected extra reply byte %h at %0t", txData, $time);
            errors++;
            break;
         end
      end
   endtask

   initial
   begin
      logic [7:0] kind;
      bit         ok;
      int         fd;
      int         recNo;
      int         passed;
      int         failed;
      int         errBefore;
      RST     = 1'b0;
      rxData  = 8'h00;
      rxValid = 1'b0;
      txReady = 1'b0;
      errors  = 0;
      recNo   = 0;
      passed  = 0;
      failed  = 0;
      idleCycles(8);
      RST = 1'b1;
      idleCycles(2);

      fd = $fopen("test/cmdProc_golden.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the golden file test/cmdProc_golden.txt");
         errors++;
      end
      else
      begin
         readRecord(fd, ok, kind);
         while (ok)
         begin
            errBefore = errors;
            recNo++;
            sendBytes();
            if (kind == "T")
               idleCycles(`FRAME_TIMEOUT + 4);
            collectReply();
            if (errors == errBefore)
            begin
               passed++;
               $display("Record %0d (%c): pass", recNo, kind);
            end
            else
            begin
               failed++;
               $display("Record %0d (%c): fail", recNo, kind);
            end
            readRecord(fd, ok, kind);
         end
         $fclose(fd);
      end

      $display("Records %0d, passed %0d, failed %0d, errors %0d", recNo, passed, failed, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== rtl/cmdProcessor.sv ====
`timescale 1ns/1ps
`include "cmdProc_macros.svh"

module cmdProcessor
   import cmdProcPkg::*;
(
   input  logic       CLK,
   input  logic       RST,
   input  logic [7:0] rxData,
   input  logic       rxValid,
   output logic       rxReady,
   output logic [7:0] txData,
   output logic       txValid,
   input  logic       txReady
);

   regWrT                  regWr;
   logic                   rdEn;
   logic [`REG_ADDR_W-1:0] rdAddr;
   logic [7:0]             rdData;
   logic                   rdValid;
   logic [7:0]             opA;
   logic [7:0]             opB;
   logic                   aluStart;
   aluOpT                  aluOp;
   aluResT                 aluRes;
   logic                   timerClr;
   logic                   expired;

   sysCtrl u_sysCtrl (
      .CLK(CLK), .RST(RST),
      .rxData(rxData), .rxValid(rxValid), .rxReady(rxReady),
      .txData(txData), .txValid(txValid), .txReady(txReady),
      .regWr(regWr), .rdEn(rdEn), .rdAddr(rdAddr),
      .rdData(rdData), .rdValid(rdValid),
      .aluStart(aluStart), .aluOp(aluOp), .aluRes(aluRes),
      .timerClr(timerClr), .expired(expired)
   );

   frameTimer u_frameTimer (.CLK(CLK), .RST(RST), .clr(timerClr), .expired(expired));

   regFile u_regFile (
      .CLK(CLK), .RST(RST), .regWr(regWr), .rdEn(rdEn), .rdAddr(rdAddr),
      .rdData(rdData), .rdValid(rdValid), .opA(opA), .opB(opB)
   );

   aluUnit u_aluUnit (
      .CLK(CLK), .RST(RST), .start(aluStart), .op(aluOp),
      .opA(opA), .opB(opB), .res(aluRes)
   );

endmodule

// ==== rtl/sysCtrl.sv ====
`timescale 1ns/1ps
`include "cmdProc_macros.svh"

module sysCtrl
   import cmdProcPkg::*;
(
   input  logic                   CLK,
   input  logic                   RST,
   input  logic [7:0]             rxData,
   input  logic                   rxValid,
   output logic                   rxReady,
   output logic [7:0]             txData,
   output logic                   txValid,
   input  logic                   txReady,
   output regWrT                  regWr,
   output logic                   rdEn,
   output logic [`REG_ADDR_W-1:0] rdAddr,
   input  logic [7:0]             rdData,
   input  logic                   rdValid,
   output logic                   aluStart,
   output aluOpT                  aluOp,
   input  aluResT                 aluRes,
   output logic                   timerClr,
   input  logic                   expired
);

   ctrlStateT              state;
   cmdT                    cmdQ;
   logic [`REG_ADDR_W-1:0] addrQ;
   logic [15:0]            replyVal;
   logic                   collecting;
   logic                   rxTake;
   logic                   opValid;

   assign collecting = state inside {GET_ADDR, GET_DATA, GET_OPA, GET_OPB, GET_OPCODE};

   // Opcode waits while operand B is still being written
   assign rxReady = (state == IDLE) ||
                    (collecting && !expired && !(state == GET_OPCODE && regWr.en));
   assign rxTake  = rxValid && rxReady;
   assign opValid = rxData < 8'd8;

   assign aluStart = (state == GET_OPCODE) && rxTake && opValid;
   assign aluOp    = aluOpT'(rxData[3:0]);
   assign rdEn     = (state == GET_ADDR) && rxTake && (cmdQ == CMD_READ);
   assign rdAddr   = rxData[`REG_ADDR_W-1:0];
   assign timerClr = (state == IDLE) || rxTake;

   assign txValid = (state == SEND_LO) || (state == SEND_HI);
   assign txData  = (state == SEND_HI) ? replyVal[15:8] : replyVal[7:0];

   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
      begin
         state    <= IDLE;
         cmdQ     <= CMD_WRITE;
         addrQ    <= '0;
         replyVal <= '0;
         regWr    <= '0;
      end
      else
      begin
         regWr.en <= 1'b0;
         if (collecting && expired)
            state <= IDLE;
         else
         begin
            case (state)
               IDLE:
                  if (rxTake)
                  begin
                     cmdQ <= cmdT'(rxData);
                     case (rxData)
                        CMD_WRITE, CMD_READ: state <= GET_ADDR;
                        CMD_ALU_OPS:         state <= GET_OPA;
                        CMD_ALU:             state <= GET_OPCODE;
                        default:             state <= IDLE;
                     endcase
                  end
               GET_ADDR:
                  if (rxTake)
                  begin
                     addrQ <= rxData[`REG_ADDR_W-1:0];
                     state <= (cmdQ == CMD_WRITE) ? GET_DATA : RD_WAIT;
                  end
               GET_DATA:
                  if (rxTake)
                  begin
                     regWr    <= '{en: 1'b1, addr: addrQ, data: rxData};
                     replyVal <= {8'h00, rxData};
                     state    <= RD_WAIT;
                  end
               GET_OPA:
                  if (rxTake)
                  begin
                     regWr <= '{en: 1'b1, addr: '0, data: rxData};
                     state <= GET_OPB;
                  end
               GET_OPB:
                  if (rxTake)
                  begin
                     regWr <= '{en: 1'b1, addr: `REG_ADDR_W'(1), data: rxData};
                     state <= GET_OPCODE;
                  end
               GET_OPCODE:
                  if (rxTake)
                     state <= opValid ? ALU_WAIT : IDLE;
               // Write echo also passes through here one cycle behind the write
               RD_WAIT:
                  if (cmdQ == CMD_WRITE)
                     state <= SEND_LO;
                  else if (rdValid)
                  begin
                     replyVal <= {8'h00, rdData};
                     state    <= SEND_LO;
                  end
               ALU_WAIT:
                  if (aluRes.done)
                  begin
                     replyVal <= aluRes.value;
                     state    <= SEND_LO;
                  end
               SEND_LO:
                  if (txReady)
                     state <= (cmdQ inside {CMD_ALU_OPS, CMD_ALU}) ? SEND_HI : IDLE;
               SEND_HI:
                  if (txReady)
                     state <= IDLE;
               default:
                  state <= IDLE;
            endcase
         end
      end
   end

   // Reply byte must hold under back-pressure
   assert property (@(posedge CLK) disable iff (!RST)
      txValid && !txReady |=> txValid && $stable(txData));

   // ALU never starts while an operand write is still pending
   assert property (@(posedge CLK) disable iff (!RST)
      aluStart |-> !regWr.en);

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit
   import cmdProcPkg::*;
(
   input  logic       CLK,
   input  logic       RST,
   input  logic       start,
   input  aluOpT      op,
   input  logic [7:0] opA,
   input  logic [7:0] opB,
   output aluResT     res
);

   logic [15:0] a16;
   logic [15:0] b16;
   logic [15:0] result;

   assign a16 = {8'h00, opA};
   assign b16 = {8'h00, opB};

   always_comb
   begin
      case (op)
         ALU_ADD: result = a16 + b16;
         ALU_SUB: result = a16 - b16;
         ALU_MUL: result = a16 * b16;
         ALU_AND: result = a16 & b16;
         ALU_OR:  result = a16 | b16;
         ALU_XOR: result = a16 ^ b16;
         // Shift amount is the low 3 bits of B
         ALU_SHL: result = a16 << opB[2:0];
         ALU_SHR: result = a16 >> opB[2:0];
         default: result = '0;
      endcase
   end

   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
         res <= '0;
      else
      begin
         res.done <= start;
         if (start)
            res.value <= result;
      end
   end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps
`include "cmdProc_macros.svh"

module regFile
   import cmdProcPkg::*;
(
   input  logic                   CLK,
   input  logic                   RST,
   input  regWrT                  regWr,
   input  logic                   rdEn,
   input  logic [`REG_ADDR_W-1:0] rdAddr,
   output logic [7:0]             rdData,
   output logic                   rdValid,
   output logic [7:0]             opA,
   output logic [7:0]             opB
);

   logic [7:0] mem [`REG_DEPTH];

   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
      begin
         for (int i = 0; i < `REG_DEPTH; i++)
            mem[i] <= '0;
      end
      else if (regWr.en)
         mem[regWr.addr] <= regWr.data;
   end

   // Registered read, valid one cycle after rdEn
   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
      begin
         rdData  <= '0;
         rdValid <= 1'b0;
      end
      else
      begin
         rdValid <= rdEn;
         if (rdEn)
            rdData <= mem[rdAddr];
      end
   end

   // ALU operand taps
   assign opA = mem[0];
   assign opB = mem[1];

   assert property (@(posedge CLK) disable iff (!RST) !(regWr.en && rdEn));

endmodule

// ==== rtl/frameTimer.sv ====
`timescale 1ns/1ps
`include "cmdProc_macros.svh"

module frameTimer
(
   input  logic CLK,
   input  logic RST,
   input  logic clr,
   output logic expired
);

   localparam int CntW = $clog2(`FRAME_TIMEOUT + 1);

   logic [CntW-1:0] cnt;

   // Saturates at the timeout
   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
         cnt <= '0;
      else if (clr)
         cnt <= '0;
      else if (cnt != CntW'(`FRAME_TIMEOUT))
         cnt <= cnt + 1'b1;
   end

   assign expired = (cnt == CntW'(`FRAME_TIMEOUT));

   assert property (@(posedge CLK) disable iff (!RST) clr |=> !expired);

endmodule

// ==== rtl/cmdProcPkg.sv ====
`include "cmdProc_macros.svh"

package cmdProcPkg;

   // Frame command codes
   typedef enum logic [7:0] {
      CMD_WRITE   = 8'hAA,
      CMD_READ    = 8'hBB,
      CMD_ALU_OPS = 8'hCC,
      CMD_ALU     = 8'hDD
   } cmdT;

   // Codes 8 to 15 are invalid
   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_MUL = 4'd2,
      ALU_AND = 4'd3,
      ALU_OR  = 4'd4,
      ALU_XOR = 4'd5,
      ALU_SHL = 4'd6,
      ALU_SHR = 4'd7
   } aluOpT;

   typedef enum logic [3:0] {
      IDLE,
      GET_ADDR,
      GET_DATA,
      GET_OPA,
      GET_OPB,
      GET_OPCODE,
      RD_WAIT,
      ALU_WAIT,
      SEND_LO,
      SEND_HI
   } ctrlStateT;

   typedef struct packed {
      logic                   en;
      logic [`REG_ADDR_W-1:0] addr;
      logic [7:0]             data;
   } regWrT;

   typedef struct packed {
      logic        done;
      logic [15:0] value;
   } aluResT;

endpackage

// ==== rtl/cmdProc_macros.svh ====
`ifndef CMD_PROC_MACROS_SVH
`define CMD_PROC_MACROS_SVH

// Register file geometry
`define REG_DEPTH 16
`define REG_ADDR_W 4

// Idle cycles allowed between two bytes of one frame
`define FRAME_TIMEOUT 64

`endif
